//--- rv_pipe_top.f
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/pipe_reg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_unit.sv
rtl/rv_pipe_top.sv
verification/rv_pipe_assert.sv
verification/rv_pipe_tb.sv

//--- Bender.yml
package:
  name: rv_pipe

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/rv_pipe_pkg.sv
  - rtl/pipe_reg.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/memory_stage.sv
  - rtl/hazard_unit.sv
  - rtl/rv_pipe_top.sv
  - target: test
    files:
      - verification/rv_pipe_assert.sv
      - verification/rv_pipe_tb.sv

//--- verification/rv_pipe_tb.sv
module rv_pipe_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned IMEM_WORDS      = 64;
    localparam int unsigned DMEM_WORDS      = 64;
    localparam int          NUM_TESTS       = 6;
    // every test loads a full image of IMEM_WORDS words
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * IMEM_WORDS * 10 + 200;

    logic                 clk_i;
    logic                 arst_n_i;
    logic                 run_i;
    logic                 imem_we_i;
    logic [31:0]          imem_addr_i;
    rv_isa_pkg::word_t    imem_wdata_i;
    rv_pipe_pkg::retire_t retire_o;

    rv_isa_pkg::word_t    prog_q [$];
    rv_pipe_pkg::retire_t exp_q [$];
    rv_pipe_pkg::retire_t got_q [$];
    rv_isa_pkg::word_t    halt_pc;
    logic [31:0]          lfsr_q = 32'hf457_76f7;
    int                   retire_errs = 0;
    int                   count_errs = 0;
    int                   other_errs = 0;

    rv_pipe_top #(
        .IMEM_WORDS(IMEM_WORDS),
        .DMEM_WORDS(DMEM_WORDS)
    ) i_dut (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .run_i(run_i), .imem_we_i(imem_we_i),
        .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i), .retire_o(retire_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // retire port settles after the rising edge
    always @(negedge clk_i) begin
        if (arst_n_i === 1'b1 && retire_o.valid === 1'b1) begin
            got_q.push_back(retire_o);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    // small assembler for the supported subset
    function automatic rv_isa_pkg::word_t rtype(input int f3, input int sub, input int rd,
                                                input int rs1, input int rs2);
        return {1'b0, 1'(sub), 5'b0, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic rv_isa_pkg::word_t addi(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic rv_isa_pkg::word_t lui(input int rd, input int imm);
        return {20'(imm), 5'(rd), 7'b0110111};
    endfunction

    function automatic rv_isa_pkg::word_t lw(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic rv_isa_pkg::word_t sw(input int rs2, input int rs1, input int imm);
        logic [11:0] o;
        o = 12'(imm);
        return {o[11:5], 5'(rs2), 5'(rs1), 3'b010, o[4:0], 7'b0100011};
    endfunction

    function automatic rv_isa_pkg::word_t branch(input int f3, input int rs1, input int rs2,
                                                 input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic rv_isa_pkg::word_t jal(input int rd, input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic check_retire(input int idx, input rv_pipe_pkg::retire_t got,
                                input rv_pipe_pkg::retire_t exp);
        if (got.pc !== exp.pc) begin
            retire_errs++;
            $display("[ERROR] %0d ns retire_o.pc #%0d: got %h expected %h",
                     $time, idx, got.pc, exp.pc);
        end
        if (got.rd !== exp.rd) begin
            retire_errs++;
            $display("[ERROR] %0d ns retire_o.rd #%0d: got %0d expected %0d",
                     $time, idx, got.rd, exp.rd);
        end
        if (got.data !== exp.data) begin
            retire_errs++;
            $display("[ERROR] %0d ns retire_o.data #%0d: got %h expected %h",
                     $time, idx, got.data, exp.data);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            count_errs++;
            $display("[ERROR] %0d ns retire count (%s): got %0d expected %0d",
                     $time, what, got, exp);
        end
    endtask

    // architectural model stepping one instruction at a time
    task automatic build_expected();
        rv_isa_pkg::word_t    regs [32];
        rv_isa_pkg::word_t    mem [int];
        rv_isa_pkg::word_t    pc;
        rv_isa_pkg::word_t    next_pc;
        rv_isa_pkg::word_t    instr;
        rv_isa_pkg::word_t    a;
        rv_isa_pkg::word_t    b;
        rv_isa_pkg::word_t    res;
        rv_isa_pkg::word_t    i_imm;
        rv_isa_pkg::word_t    s_imm;
        rv_isa_pkg::word_t    b_imm;
        rv_isa_pkg::word_t    j_imm;
        rv_pipe_pkg::retire_t r;
        logic                 wr;
        int                   steps;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        exp_q.delete();
        pc = '0;
        steps = 0;
        while (pc != halt_pc && steps < 500) begin
            instr   = prog_q[pc >> 2];
            a       = regs[instr[19:15]];
            b       = regs[instr[24:20]];
            i_imm   = $signed(instr) >>> 20;
            s_imm   = {i_imm[31:5], instr[11:7]};
            b_imm   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            j_imm   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            wr      = 1'b1;
            res     = '0;
            next_pc = pc + 32'd4;
            case (instr[6:0])
                7'b0110011: begin
                    case (instr[14:12])
                        3'b000:  res = instr[30] ? a - b : a + b;
                        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                end
                7'b0010011: res = a + i_imm;
                7'b0110111: res = {instr[31:12], 12'h000};
                7'b0000011: res = mem[(a + i_imm) >> 2];
                7'b0100011: begin
                    mem[(a + s_imm) >> 2] = b;
                    wr = 1'b0;
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if ((a == b) != instr[12]) begin // funct3 bit 0 selects bne
                        next_pc = pc + b_imm;
                    end
                end
                default: begin // jal
                    res     = pc + 32'd4;
                    next_pc = pc + j_imm;
                end
            endcase
            if (wr && instr[11:7] != 5'd0) begin
                regs[instr[11:7]] = res;
                r.valid = 1'b1;
                r.pc    = pc;
                r.rd    = instr[11:7];
                r.data  = res;
                exp_q.push_back(r);
            end
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        arst_n_i <= 1'b0;
        run_i    <= 1'b0;
        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;
    endtask

    // words past the program jump back to the self loop at halt_pc
    task automatic load_program();
        halt_pc = 32'(prog_q.size() * 4);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            @(posedge clk_i);
            imem_we_i    <= 1'b1;
            imem_addr_i  <= 32'(i * 4);
            imem_wdata_i <= (i < prog_q.size()) ? prog_q[i] : jal(0, int'(halt_pc) - i * 4);
        end
        @(posedge clk_i);
        imem_we_i <= 1'b0;
    endtask

    task automatic run_program(input string name, input int idle_cycles);
        int cycles;
        int limit;
        apply_reset();
        load_program();
        build_expected();
        got_q.delete();
        repeat (idle_cycles) @(posedge clk_i);
        check_count({name, ", run low"}, got_q.size(), 0);
        run_i <= 1'b1;
        limit  = prog_q.size() * 10 + 50;
        cycles = 0;
        while (got_q.size() < exp_q.size() && cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        if (got_q.size() < exp_q.size()) begin
            other_errs++;
            $display("%s: timed out waiting for the expected retirements", name);
        end
        repeat (8) @(posedge clk_i); // catch stray retirements
        check_count(name, got_q.size(), exp_q.size());
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_retire(i, got_q[i], exp_q[i]);
        end
        run_i <= 1'b0;
    endtask

    task automatic alu_imm_ops();
        prog_q.delete();
        prog_q.push_back(addi(1, 0, rand_bits(12)));
        prog_q.push_back(addi(2, 0, rand_bits(12)));
        prog_q.push_back(lui(3, rand_bits(20)));
        prog_q.push_back(addi(11, 3, rand_bits(12)));
        prog_q.push_back(rtype(rv_isa_pkg::F3_ADD_SUB, 0, 4, 1, 2));
        prog_q.push_back(rtype(rv_isa_pkg::F3_ADD_SUB, 1, 5, 1, 2));
        prog_q.push_back(rtype(rv_isa_pkg::F3_AND, 0, 6, 1, 2));
        prog_q.push_back(rtype(rv_isa_pkg::F3_OR, 0, 7, 1, 2));
        prog_q.push_back(rtype(rv_isa_pkg::F3_XOR, 0, 8, 1, 2));
        prog_q.push_back(rtype(rv_isa_pkg::F3_SLT, 0, 9, 1, 2));
        prog_q.push_back(rtype(rv_isa_pkg::F3_SLT, 0, 10, 2, 1));
        run_program("alu and immediates", 5);
    endtask

    // each op reads the result one and two slots back
    task automatic forwarding_chain();
        prog_q.delete();
        prog_q.push_back(addi(1, 0, rand_bits(12)));
        prog_q.push_back(addi(2, 1, rand_bits(12)));
        prog_q.push_back(rtype(rv_isa_pkg::F3_ADD_SUB, 0, 3, 2, 1));
        prog_q.push_back(rtype(rv_isa_pkg::F3_ADD_SUB, 1, 4, 3, 2));
        prog_q.push_back(rtype(rv_isa_pkg::F3_XOR, 0, 5, 4, 3));
        prog_q.push_back(rtype(rv_isa_pkg::F3_OR, 0, 6, 5, 4));
        prog_q.push_back(rtype(rv_isa_pkg::F3_AND, 0, 7, 6, 5));
        prog_q.push_back(rtype(rv_isa_pkg::F3_SLT, 0, 8, 7, 6));
        prog_q.push_back(lui(10, rand_bits(20)));
        prog_q.push_back(addi(10, 10, rand_bits(12)));
        prog_q.push_back(rtype(rv_isa_pkg::F3_ADD_SUB, 0, 10, 10, 10)); // newest x10 wins
        run_program("forwarding chain", 5);
    endtask

    task automatic load_use_stall();
        prog_q.delete();
        prog_q.push_back(addi(1, 0, rand_bits(12)));
        prog_q.push_back(addi(2, 0, 64));
        prog_q.push_back(sw(1, 2, 0));
        prog_q.push_back(lw(3, 2, 0));
        prog_q.push_back(rtype(rv_isa_pkg::F3_ADD_SUB, 0, 4, 3, 1));
        prog_q.push_back(addi(5, 1, rand_bits(12)));
        prog_q.push_back(sw(5, 2, 4));
        prog_q.push_back(lw(6, 2, 4));
        prog_q.push_back(sw(6, 2, 8)); // load feeds store data
        prog_q.push_back(lw(7, 2, 8));
        prog_q.push_back(rtype(rv_isa_pkg::F3_ADD_SUB, 1, 8, 1, 7));
        prog_q.push_back(lw(9, 2, 4));
        prog_q.push_back(addi(0, 0, 0));
        prog_q.push_back(rtype(rv_isa_pkg::F3_ADD_SUB, 0, 10, 9, 9));
        run_program("store, load and load use", 5);
    endtask

    task automatic branch_and_jal();
        prog_q.delete();
        prog_q.push_back(addi(1, 0, 5));
        prog_q.push_back(addi(2, 0, 5));
        prog_q.push_back(addi(3, 0, 7));
        prog_q.push_back(branch(3'b000, 1, 2, 12)); // beq taken
        prog_q.push_back(addi(10, 0, 1));
        prog_q.push_back(addi(11, 0, 1));
        prog_q.push_back(branch(3'b001, 1, 2, 8)); // bne not taken
        prog_q.push_back(addi(4, 0, 2));
        prog_q.push_back(branch(3'b001, 1, 3, 12)); // bne taken
        prog_q.push_back(addi(12, 0, 1));
        prog_q.push_back(addi(13, 0, 1));
        prog_q.push_back(jal(5, 12));
        prog_q.push_back(addi(14, 0, 1));
        prog_q.push_back(addi(15, 0, 1));
        prog_q.push_back(addi(6, 5, 1));
        prog_q.push_back(branch(3'b000, 1, 3, 8)); // beq not taken
        prog_q.push_back(addi(7, 0, 9));
        prog_q.push_back(branch(3'b000, 0, 0, 8));
        prog_q.push_back(addi(16, 0, 1));
        prog_q.push_back(addi(8, 7, 3));
        run_program("branches and jal", 5);
    endtask

    task automatic x0_writes();
        prog_q.delete();
        prog_q.push_back(addi(1, 0, rand_bits(12)));
        prog_q.push_back(addi(0, 1, 5));
        prog_q.push_back(rtype(rv_isa_pkg::F3_ADD_SUB, 0, 2, 0, 0));
        prog_q.push_back(rtype(rv_isa_pkg::F3_ADD_SUB, 0, 3, 0, 1));
        prog_q.push_back(lui(0, rand_bits(20)));
        prog_q.push_back(addi(4, 0, 0));
        prog_q.push_back(rtype(rv_isa_pkg::F3_OR, 0, 5, 0, 1));
        run_program("writes to x0", 5);
    endtask

    task automatic run_gating();
        prog_q.delete();
        prog_q.push_back(addi(1, 0, rand_bits(12)));
        prog_q.push_back(addi(2, 1, rand_bits(12)));
        run_program("run control", 20);
        if (got_q.size() == 0 || got_q[0].pc != 32'd0) begin
            other_errs++;
            $display("run control: first retirement after run_i rose did not come from pc 0");
        end
    endtask

    initial begin
        arst_n_i     = 1'b1;
        run_i        = 1'b0;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        halt_pc      = '0;
        alu_imm_ops();
        forwarding_chain();
        load_use_stall();
        branch_and_jal();
        x0_writes();
        run_gating();
        $display("errors: %0d retire mismatches, %0d count mismatches, %0d other failures",
                 retire_errs, count_errs, other_errs);
        if (retire_errs + count_errs + other_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- verification/rv_pipe_assert.sv
module rv_pipe_assert (
    input logic                   clk_i,
    input logic                   arst_n_i,
    input rv_pipe_pkg::retire_t   retire_i,
    input rv_pipe_pkg::redirect_t redirect_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // reset clears every stage, so nothing can leave the pipe
    a_no_retire_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !retire_i.valid)
        else $error("retire_o.valid high while reset is asserted");

    a_retire_fields: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        retire_i.valid |-> (retire_i.rd != '0) && (retire_i.pc[1:0] == 2'b00))
        else $error("retire_o carries rd zero or a misaligned pc");

    // the two killed slots would reach writeback three and four cycles on
    a_flushed_slots: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        redirect_i.taken |-> ##3 !retire_i.valid ##1 !retire_i.valid)
        else $error("instruction behind a taken redirect retired");

endmodule

bind rv_pipe_top rv_pipe_assert i_assert (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .retire_i(retire_o), .redirect_i(redirect)
);

//--- rtl/rv_pipe_top.sv
module rv_pipe_top #(
    parameter int unsigned IMEM_WORDS = 256,
    parameter int unsigned DMEM_WORDS = 256
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 run_i,
    input  logic                 imem_we_i,
    input  logic [31:0]          imem_addr_i,
    input  rv_isa_pkg::word_t    imem_wdata_i,
    output rv_pipe_pkg::retire_t retire_o
);

    rv_pipe_pkg::if_id_t    if_f;
    rv_pipe_pkg::if_id_t    if_d;
    rv_pipe_pkg::id_ex_t    id_d;
    rv_pipe_pkg::id_ex_t    id_e;
    rv_pipe_pkg::ex_mem_t   ex_e;
    rv_pipe_pkg::ex_mem_t   ex_m;
    rv_pipe_pkg::mem_wb_t   mem_m;
    rv_pipe_pkg::mem_wb_t   mem_w;
    rv_pipe_pkg::redirect_t redirect;
    logic                   stall_f;
    logic                   stall_d;
    logic                   flush_d;
    logic                   flush_e;

    fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) i_fetch (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .run_i(run_i), .stall_i(stall_f),
        .redirect_i(redirect), .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i),
        .imem_wdata_i(imem_wdata_i), .if_o(if_f)
    );

    pipe_reg #(.T(rv_pipe_pkg::if_id_t)) i_if_id (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(stall_d), .flush_i(flush_d),
        .d_i(if_f), .q_o(if_d)
    );

    decode_stage i_decode (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .if_i(if_d), .wb_i(mem_w),
        .id_o(id_d), .retire_o(retire_o)
    );

    pipe_reg #(.T(rv_pipe_pkg::id_ex_t)) i_id_ex (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(1'b0), .flush_i(flush_e),
        .d_i(id_d), .q_o(id_e)
    );

    execute_stage i_execute (
        .id_i(id_e), .mem_fwd_i(ex_m), .wb_fwd_i(mem_w), .ex_o(ex_e), .redirect_o(redirect)
    );

    // back half never stalls or flushes
    pipe_reg #(.T(rv_pipe_pkg::ex_mem_t)) i_ex_mem (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(1'b0), .flush_i(1'b0),
        .d_i(ex_e), .q_o(ex_m)
    );

    memory_stage #(.DMEM_WORDS(DMEM_WORDS)) i_memory (
        .clk_i(clk_i), .ex_i(ex_m), .mem_o(mem_m)
    );

    pipe_reg #(.T(rv_pipe_pkg::mem_wb_t)) i_mem_wb (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(1'b0), .flush_i(1'b0),
        .d_i(mem_m), .q_o(mem_w)
    );

    hazard_unit i_hazard (
        .if_id_i(if_d), .id_ex_i(id_e), .redirect_i(redirect),
        .stall_f_o(stall_f), .flush_d_o(flush_d), .stall_d_o(stall_d), .flush_e_o(flush_e)
    );

endmodule

//--- rtl/hazard_unit.sv
module hazard_unit (
    input  rv_pipe_pkg::if_id_t    if_id_i,
    input  rv_pipe_pkg::id_ex_t    id_ex_i,
    input  rv_pipe_pkg::redirect_t redirect_i,
    output logic                   stall_f_o,
    output logic                   flush_d_o,
    output logic                   stall_d_o,
    output logic                   flush_e_o
);

    rv_isa_pkg::reg_addr_t rs1_d;
    rv_isa_pkg::reg_addr_t rs2_d;
    logic                  load_use;

    assign rs1_d = rv_isa_pkg::get_rs1(if_id_i.instr);
    assign rs2_d = rv_isa_pkg::get_rs2(if_id_i.instr);

    // load in execute feeding the instruction in decode
    assign load_use = if_id_i.valid && id_ex_i.valid && id_ex_i.ctrl.mem_to_reg &&
                      (id_ex_i.rd != '0) && (id_ex_i.rd == rs1_d || id_ex_i.rd == rs2_d);

    assign stall_f_o = load_use;
    assign stall_d_o = load_use;
    assign flush_d_o = redirect_i.taken; // kill the two younger slots
    assign flush_e_o = redirect_i.taken || load_use;

endmodule

//--- rtl/memory_stage.sv
module memory_stage #(
    parameter int unsigned DMEM_WORDS = 256
) (
    input  logic                 clk_i,
    input  rv_pipe_pkg::ex_mem_t ex_i,
    output rv_pipe_pkg::mem_wb_t mem_o
);

    localparam int unsigned IDX_W = $clog2(DMEM_WORDS);

    rv_isa_pkg::word_t  dmem [DMEM_WORDS];
    logic [IDX_W-1:0]   idx;

    assign idx = ex_i.alu_result[IDX_W+1:2]; // word index, low bits ignored

    always_ff @(posedge clk_i) begin
        if (ex_i.valid && ex_i.ctrl.mem_write) begin
            dmem[idx] <= ex_i.store_data;
        end
    end

    always_comb begin
        mem_o.valid      = ex_i.valid;
        mem_o.pc         = ex_i.pc;
        mem_o.rd         = ex_i.rd;
        mem_o.alu_result = ex_i.alu_result;
        mem_o.load_data  = dmem[idx]; // async read
        mem_o.ctrl       = ex_i.ctrl;
    end

endmodule

//--- rtl/execute_stage.sv
module execute_stage (
    input  rv_pipe_pkg::id_ex_t    id_i,
    input  rv_pipe_pkg::ex_mem_t   mem_fwd_i,
    input  rv_pipe_pkg::mem_wb_t   wb_fwd_i,
    output rv_pipe_pkg::ex_mem_t   ex_o,
    output rv_pipe_pkg::redirect_t redirect_o
);

    rv_isa_pkg::word_t op_a;
    rv_isa_pkg::word_t fwd_b;
    rv_isa_pkg::word_t op_b;
    rv_isa_pkg::word_t alu_out;
    logic              eq;

    // memory stage wins over writeback, x0 never forwarded
    function automatic rv_isa_pkg::word_t fwd_operand(
        rv_isa_pkg::reg_addr_t rs,
        rv_isa_pkg::word_t     rf_val,
        rv_pipe_pkg::ex_mem_t  m,
        rv_pipe_pkg::mem_wb_t  w
    );
        rv_isa_pkg::word_t val;
        val = rf_val;
        if (m.valid && m.ctrl.reg_write && m.rd != '0 && m.rd == rs) begin
            val = m.alu_result;
        end else if (w.valid && w.ctrl.reg_write && w.rd != '0 && w.rd == rs) begin
            val = w.ctrl.mem_to_reg ? w.load_data : w.alu_result;
        end
        return val;
    endfunction

    assign op_a  = fwd_operand(id_i.rs1, id_i.rs1_data, mem_fwd_i, wb_fwd_i);
    assign fwd_b = fwd_operand(id_i.rs2, id_i.rs2_data, mem_fwd_i, wb_fwd_i);
    assign op_b  = id_i.ctrl.alu_src_imm ? id_i.imm : fwd_b;

    always_comb begin
        case (id_i.ctrl.alu_op)
            rv_isa_pkg::ALU_ADD:    alu_out = op_a + op_b;
            rv_isa_pkg::ALU_SUB:    alu_out = op_a - op_b;
            rv_isa_pkg::ALU_AND:    alu_out = op_a & op_b;
            rv_isa_pkg::ALU_OR:     alu_out = op_a | op_b;
            rv_isa_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            rv_isa_pkg::ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_isa_pkg::ALU_PASS_B: alu_out = op_b;
            default:                alu_out = '0;
        endcase
    end

    // branch compare on forwarded registers, not the immediate
    assign eq = (op_a == fwd_b);

    always_comb begin
        redirect_o.taken  = id_i.valid && (id_i.ctrl.jump ||
                            (id_i.ctrl.branch && (id_i.ctrl.branch_ne ? !eq : eq)));
        redirect_o.target = id_i.pc + id_i.imm;
    end

    always_comb begin
        ex_o.valid      = id_i.valid;
        ex_o.pc         = id_i.pc;
        ex_o.rd         = id_i.rd;
        ex_o.alu_result = id_i.ctrl.jump ? id_i.pc + 32'd4 : alu_out; // link value
        ex_o.store_data = fwd_b;
        ex_o.ctrl       = id_i.ctrl;
    end

endmodule

//--- rtl/decode_stage.sv
module decode_stage (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  rv_pipe_pkg::if_id_t  if_i,
    input  rv_pipe_pkg::mem_wb_t wb_i,
    output rv_pipe_pkg::id_ex_t  id_o,
    output rv_pipe_pkg::retire_t retire_o
);

    rv_isa_pkg::word_t     instr;
    rv_isa_pkg::op_e       opcode;
    logic [2:0]            funct3;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    rv_pipe_pkg::ctrl_t    ctrl;
    rv_isa_pkg::word_t     imm;

    rv_isa_pkg::word_t     regs [32];  // entry 0 never written
    logic                  wr_en;
    rv_isa_pkg::word_t     wr_data;

    assign instr  = if_i.instr;
    assign opcode = rv_isa_pkg::op_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1    = rv_isa_pkg::get_rs1(instr);
    assign rs2    = rv_isa_pkg::get_rs2(instr);

    // control and immediate decode
    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: begin
                        ctrl.alu_op = instr[30] ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
                    end
                    rv_isa_pkg::F3_SLT: ctrl.alu_op = rv_isa_pkg::ALU_SLT;
                    rv_isa_pkg::F3_XOR: ctrl.alu_op = rv_isa_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:  ctrl.alu_op = rv_isa_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND: ctrl.alu_op = rv_isa_pkg::ALU_AND;
                    default: ctrl.reg_write = 1'b0; // shifts etc not supported
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM: begin // addi only
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            rv_isa_pkg::OPC_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = rv_isa_pkg::ALU_PASS_B;
                imm = {instr[31:12], 12'b0};
            end
            rv_isa_pkg::OPC_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            rv_isa_pkg::OPC_STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rv_isa_pkg::OPC_BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (funct3 == rv_isa_pkg::F3_BNE);
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv_isa_pkg::OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    // writeback select, shared by regfile and retire port
    assign wr_data = wb_i.ctrl.mem_to_reg ? wb_i.load_data : wb_i.alu_result;
    assign wr_en   = wb_i.valid && wb_i.ctrl.reg_write && (wb_i.rd != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wr_data;
        end
    end

    always_comb begin
        id_o.valid = if_i.valid;
        id_o.pc    = if_i.pc;
        id_o.rs1   = rs1;
        id_o.rs2   = rs2;
        id_o.rd    = rv_isa_pkg::get_rd(instr);
        // same-cycle write is bypassed to the read
        id_o.rs1_data = (wr_en && wb_i.rd == rs1) ? wr_data : regs[rs1];
        id_o.rs2_data = (wr_en && wb_i.rd == rs2) ? wr_data : regs[rs2];
        id_o.imm   = imm;
        id_o.ctrl  = ctrl;
    end

    always_comb begin
        retire_o.valid = wr_en;
        retire_o.pc    = wb_i.pc;
        retire_o.rd    = wb_i.rd;
        retire_o.data  = wr_data;
    end

endmodule

//--- rtl/fetch_stage.sv
module fetch_stage #(
    parameter int unsigned IMEM_WORDS = 256
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   run_i,
    input  logic                   stall_i,
    input  rv_pipe_pkg::redirect_t redirect_i,
    input  logic                   imem_we_i,
    input  logic [31:0]            imem_addr_i,  // byte address
    input  rv_isa_pkg::word_t      imem_wdata_i,
    output rv_pipe_pkg::if_id_t    if_o
);

    localparam int unsigned IDX_W = $clog2(IMEM_WORDS);

    rv_isa_pkg::word_t imem [IMEM_WORDS];
    rv_isa_pkg::word_t pc_q;
    rv_isa_pkg::word_t pc_d;

    // program load port
    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem[imem_addr_i[IDX_W+1:2]] <= imem_wdata_i;
        end
    end

    always_comb begin
        pc_d = pc_q;
        if (redirect_i.taken) begin
            pc_d = redirect_i.target; // branch or jal from execute
        end else if (run_i && !stall_i) begin
            pc_d = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_d;
        end
    end

    always_comb begin
        if_o.valid = run_i;
        if_o.pc    = pc_q;
        if_o.instr = imem[pc_q[IDX_W+1:2]];
    end

endmodule

//--- rtl/pipe_reg.sv
module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic stall_i,
    input  logic flush_i,
    input  T     d_i,
    output T     q_o
);

    // all-zero payload is a bubble, valid bit cleared
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

//--- rtl/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // control word decoded once, consumed downstream
    typedef struct packed {
        logic                reg_write;
        logic                mem_write;
        logic                mem_to_reg;  // also marks a load
        logic                alu_src_imm;
        logic                branch;
        logic                branch_ne;
        logic                jump;
        rv_isa_pkg::alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic              valid;
        rv_isa_pkg::word_t pc;
        rv_isa_pkg::word_t instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     rs1_data;
        rv_isa_pkg::word_t     rs2_data;
        rv_isa_pkg::word_t     imm;
        ctrl_t                 ctrl;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     alu_result;  // pc + 4 for jal
        rv_isa_pkg::word_t     store_data;
        ctrl_t                 ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     alu_result;
        rv_isa_pkg::word_t     load_data;
        ctrl_t                 ctrl;
    } mem_wb_t;

    typedef struct packed {
        logic              taken;
        rv_isa_pkg::word_t target;
    } redirect_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     data;
    } retire_t;

endpackage

//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } op_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0, // zero so a bubble decodes as add
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6  // lui
    } alu_op_e;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BNE     = 3'b001;

    function automatic reg_addr_t get_rs1(word_t instr);
        return instr[19:15];
    endfunction

    function automatic reg_addr_t get_rs2(word_t instr);
        return instr[24:20];
    endfunction

    function automatic reg_addr_t get_rd(word_t instr);
        return instr[11:7];
    endfunction

endpackage
